//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = channel_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))
PASS_MSG = Simulation finished: PASS

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/channel_assert.sv
`default_nettype none

module channel_assert #(
   parameter int NOMINAL_COUNT = 64,
   parameter int SQUARE_LAT    = 2
) (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  channel_pkg::mode_t       i_mode,
   input  logic                     i_dump,
   input  logic                     i_power_valid,
   input  logic                     i_start,
   input  channel_pkg::loop_state_t i_loop_state
);

   // Dump to power valid, three squarings plus capture and update.
   localparam int POWER_LAT = 3 * (SQUARE_LAT + 1) + 2;

   int failures = 0;

   single_dump: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dump |=> !i_dump)
      else begin
         failures++;
         $error("o_dump stayed high for more than one cycle");
      end

   no_dump_in_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(i_dump) |-> ($past(i_mode) == channel_pkg::MODE_TRACK))
      else begin
         failures++;
         $error("o_dump rose while the channel was idle");
      end

   power_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_power_valid |-> $past(i_dump, POWER_LAT))
      else begin
         failures++;
         $error("o_power_valid came without an o_dump at the fixed latency");
      end

   nominal_after_start: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_start |=> (int'(i_loop_state.tau_prime) == NOMINAL_COUNT))
      else begin
         failures++;
         $error("tau_prime is not the nominal count after start");
      end

endmodule

bind channel_top channel_assert #(
   .NOMINAL_COUNT(NOMINAL_COUNT),
   .SQUARE_LAT   (SQUARE_LAT)
) channel_assert_inst (
   .clk           (clk),
   .i_rst_n       (i_rst_n),
   .i_mode        (i_mode),
   .i_dump        (o_dump),
   .i_power_valid (o_power_valid),
   .i_start       (start),
   .i_loop_state  (o_loop_state)
);

`default_nettype wire

//--- sim/channel_tb.sv
`default_nettype none

module channel_tb;

   localparam int NOMINAL_COUNT   = 32;
   localparam int SQUARE_LAT      = 2;
   localparam int SAMPLE_W        = channel_pkg::SAMPLE_W;
   localparam int ACC_W           = channel_pkg::ACC_W;
   localparam int POWER_W         = channel_pkg::POWER_W;
   localparam int PHASE_W         = channel_pkg::PHASE_W;
   localparam int COUNT_W         = channel_pkg::COUNT_W;
   localparam int TAU_OFS_W       = channel_pkg::TAU_OFS_W;
   localparam int IQ_W            = channel_pkg::IQ_W;
   localparam int TOTAL_DUMPS     = 16;
   localparam int WATCHDOG_CYCLES = 40 * TOTAL_DUMPS * NOMINAL_COUNT;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic                       clk;
   logic                       i_rst_n;
   channel_pkg::mode_t         i_mode;
   logic                       i_sample_valid;
   logic signed [SAMPLE_W-1:0] i_sample;
   logic                       i_code_chip;
   logic                       i_tracking_ready;
   channel_pkg::loop_update_t  i_loop_update;
   logic                       i_track_carrier_en;
   logic                       i_track_code_en;
   logic                       o_dump;
   channel_pkg::corr_t         o_prompt;
   logic                       o_power_valid;
   channel_pkg::power_t        o_power;
   channel_pkg::loop_state_t   o_loop_state;

   logic [31:0] lfsr = 32'd74865;

   // Carrier levels per octant of the phase.
   int cos_level [8] = '{2, 1, -1, -2, -2, -1, 1, 2};
   int sin_level [8] = '{1, 2, 2, 1, -1, -2, -2, -1};

   // Reference model state.
   channel_pkg::mode_t       m_prev_mode;
   channel_pkg::loop_state_t m_state;
   logic [COUNT_W-1:0]       m_count;
   logic [COUNT_W-1:0]       m_tau_active;
   logic [COUNT_W-1:0]       m_tau_next;
   logic [PHASE_W-1:0]       m_phase;
   logic [PHASE_W-1:0]       m_dphi_old;
   logic [1:0]               m_taps;
   logic [2:0]               m_chips;
   logic                     m_dump;
   logic                     m_dump_old;
   logic                     m_start;
   logic                     m_track;
   logic                     m_last;
   logic                     m_ignore;
   int                       m_sum_i [3];
   int                       m_sum_q [3];
   int                       m_res_i [3];
   int                       m_res_q [3];
   int                       m_cos;
   int                       m_sin;
   int                       m_smp;
   int                       m_sgn;

   int     dump_count = 0;
   logic   power_pending = 1'b0;
   longint exp_power [3];

   channel_top #(
      .NOMINAL_COUNT(NOMINAL_COUNT),
      .SQUARE_LAT   (SQUARE_LAT)
   ) channel_top_inst (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_mode             (i_mode),
      .i_sample_valid     (i_sample_valid),
      .i_sample           (i_sample),
      .i_code_chip        (i_code_chip),
      .i_tracking_ready   (i_tracking_ready),
      .i_loop_update      (i_loop_update),
      .i_track_carrier_en (i_track_carrier_en),
      .i_track_code_en    (i_track_code_en),
      .o_dump             (o_dump),
      .o_prompt           (o_prompt),
      .o_power_valid      (o_power_valid),
      .o_power            (o_power),
      .o_loop_state       (o_loop_state)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Galois LFSR, one step per bit taken.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
         bits = {bits[30:0], lfsr[0]};
      end
      return bits;
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string msg);
      stop_with_failure($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
   endtask

   task automatic drive_sample();
      @(posedge clk);
      i_sample_valid   <= (rand_bits(2) != 32'd0);
      i_sample         <= SAMPLE_W'(rand_bits(SAMPLE_W));
      i_code_chip      <= (rand_bits(1) != 32'd0);
      i_tracking_ready <= 1'b0;
   endtask

   task automatic send_update(input logic [IQ_W-1:0] iq, input logic [PHASE_W-1:0] dinc,
                              input int ofs, input logic carrier_en, input logic code_en);
      drive_sample();
      i_tracking_ready              <= 1'b1;
      i_loop_update.iq_prompt       <= iq;
      i_loop_update.doppler_inc     <= dinc;
      i_loop_update.tau_offset      <= TAU_OFS_W'(ofs);
      i_track_carrier_en            <= carrier_en;
      i_track_code_en               <= code_en;
   endtask

   task automatic run_dumps(input int n);
      int target;
      target = dump_count + n;
      while (dump_count < target) begin
         drive_sample();
      end
   endtask

   task automatic enter_mode(input channel_pkg::mode_t mode);
      drive_sample();
      i_mode <= mode;
   endtask

   // Reference model, stepped on the same edges as the DUT.
   always @(posedge clk) begin
      if (!i_rst_n) begin
         m_prev_mode  = channel_pkg::MODE_IDLE;
         m_state      = '0;
         m_count      = '0;
         m_tau_active = '0;
         m_phase      = '0;
         m_taps       = '0;
         m_dump       = 1'b0;
         m_ignore     = 1'b0;
         for (int k = 0; k < 3; k++) begin
            m_sum_i[k] = 0;
            m_sum_q[k] = 0;
            m_res_i[k] = 0;
            m_res_q[k] = 0;
         end
      end else begin
         m_track    = (i_mode == channel_pkg::MODE_TRACK);
         m_start    = m_track && (m_prev_mode != channel_pkg::MODE_TRACK);
         m_last     = m_track && (m_count == m_tau_active - COUNT_W'(1));
         m_tau_next = m_state.tau_prime;
         if (i_tracking_ready && i_track_code_en) begin
            m_tau_next = COUNT_W'(NOMINAL_COUNT + int'($signed(i_loop_update.tau_offset)));
         end
         m_dump_old = m_dump;
         m_dphi_old = m_state.carrier_dphi;
         m_cos      = cos_level[m_phase[PHASE_W-1 -: 3]];
         m_sin      = sin_level[m_phase[PHASE_W-1 -: 3]];
         m_chips    = {m_taps[1], m_taps[0], i_code_chip};
         m_smp      = int'(i_sample);

         // History shifts before the new prompt lands.
         if (m_start) begin
            m_state               = '0;
            m_state.iq_prompt_km1 = IQ_W'(1);
            m_state.tau_prime     = COUNT_W'(NOMINAL_COUNT);
            m_ignore              = 1'b1;
         end else begin
            m_state.tau_prime = m_tau_next;
            if (i_tracking_ready) begin
               m_state.i_prompt_km1  = m_state.i_prompt_k;
               m_state.q_prompt_km1  = m_state.q_prompt_k;
               m_state.iq_prompt_km1 = i_loop_update.iq_prompt;
               if (i_track_carrier_en && !m_ignore) begin
                  m_state.carrier_dphi = i_loop_update.doppler_inc;
               end
               m_ignore = 1'b0;
            end
            if (m_dump_old) begin
               m_state.i_prompt_k = ACC_W'(m_res_i[1]);
               m_state.q_prompt_k = ACC_W'(m_res_q[1]);
            end
         end

         m_dump = 1'b0;
         if (m_start) begin
            m_count      = '0;
            m_tau_active = COUNT_W'(NOMINAL_COUNT);
         end else if (m_track && i_sample_valid) begin
            if (m_last) begin
               m_count      = '0;
               m_tau_active = m_tau_next;
               m_dump       = 1'b1;
            end else begin
               m_count = m_count + COUNT_W'(1);
            end
         end

         if (m_start) begin
            m_phase = '0;
         end else if (i_sample_valid) begin
            m_phase = m_phase + m_dphi_old;
         end

         // Early, prompt and late use tap delays 0, 1 and 2.
         for (int k = 0; k < 3; k++) begin
            m_sgn = m_chips[k] ? 1 : -1;
            if (m_start) begin
               m_sum_i[k] = 0;
               m_sum_q[k] = 0;
            end else if (i_sample_valid) begin
               if (m_last) begin
                  m_res_i[k] = m_sum_i[k] + m_sgn * m_smp * m_cos;
                  m_res_q[k] = m_sum_q[k] + m_sgn * m_smp * m_sin;
                  m_sum_i[k] = 0;
                  m_sum_q[k] = 0;
               end else begin
                  m_sum_i[k] = m_sum_i[k] + m_sgn * m_smp * m_cos;
                  m_sum_q[k] = m_sum_q[k] + m_sgn * m_smp * m_sin;
               end
            end
         end

         if (i_sample_valid) begin
            m_taps = {m_taps[0], i_code_chip};
         end
         m_prev_mode = i_mode;
      end
   end

   // Outputs compared mid-cycle, away from the active edge.
   always @(negedge clk) begin
      if (i_rst_n) begin
         if (channel_top_inst.channel_assert_inst.failures != 0) begin
            stop_with_failure("ERROR: a bound assertion on channel_top failed");
         end
         if (o_dump !== m_dump) begin
            report_mismatch($sformatf("o_dump is %0b, expected %0b", o_dump, m_dump));
         end
         if (o_loop_state !== m_state) begin
            report_mismatch($sformatf("loop state is %h, expected %h", o_loop_state, m_state));
         end
         if (dump_count == 0 && o_power !== '0) begin
            report_mismatch("o_power is not zero before the first dump");
         end
         if (o_power_valid) begin
            if (!power_pending) begin
               report_mismatch("o_power_valid without a pending dump");
            end
            if (o_power.early !== POWER_W'(exp_power[0]) ||
                o_power.prompt !== POWER_W'(exp_power[1]) ||
                o_power.late !== POWER_W'(exp_power[2])) begin
               report_mismatch($sformatf("powers %0d %0d %0d, expected %0d %0d %0d",
                  o_power.early, o_power.prompt, o_power.late,
                  exp_power[0], exp_power[1], exp_power[2]));
            end
            power_pending = 1'b0;
         end
         if (o_dump) begin
            if (int'(o_prompt.i) != m_res_i[1] || int'(o_prompt.q) != m_res_q[1]) begin
               report_mismatch($sformatf("prompt is (%0d, %0d), expected (%0d, %0d)",
                  o_prompt.i, o_prompt.q, m_res_i[1], m_res_q[1]));
            end
            for (int k = 0; k < 3; k++) begin
               exp_power[k] = longint'(m_res_i[k]) * m_res_i[k] +
                              longint'(m_res_q[k]) * m_res_q[k];
            end
            power_pending = 1'b1;
            dump_count++;
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      stop_with_failure($sformatf("ERROR: watchdog timeout, run not done after %0d cycles",
                                  WATCHDOG_CYCLES));
   end

   initial begin
      i_rst_n            <= 1'b0;
      i_mode             <= channel_pkg::MODE_IDLE;
      i_sample_valid     <= 1'b0;
      i_sample           <= '0;
      i_code_chip        <= 1'b0;
      i_tracking_ready   <= 1'b0;
      i_loop_update      <= '0;
      i_track_carrier_en <= 1'b0;
      i_track_code_en    <= 1'b0;
      repeat (5) @(posedge clk);
      i_rst_n <= 1'b1;

      // Idle with samples flowing.
      repeat (20) drive_sample();
      enter_mode(channel_pkg::MODE_TRACK);
      run_dumps(3);

      // First Doppler after start is dropped, the second one turns the carrier.
      send_update(32'h1234_5678, 16'h2000, 0, 1'b1, 1'b0);
      run_dumps(2);
      send_update(32'h1357_9bdf, 16'h2000, 0, 1'b1, 1'b0);
      run_dumps(3);

      // Shorter integration from the next restart of the count.
      send_update(32'h0246_8ace, 16'h2000, -4, 1'b1, 1'b1);
      run_dumps(3);

      // Enables low keep both controls.
      send_update(32'h0000_00ff, 16'h0100, 8, 1'b0, 1'b0);
      run_dumps(2);

      // Restart from idle, idle long enough for a full count of samples.
      enter_mode(channel_pkg::MODE_IDLE);
      repeat (2 * NOMINAL_COUNT) drive_sample();
      enter_mode(channel_pkg::MODE_TRACK);
      run_dumps(1);
      send_update(32'h0000_0042, 16'h4000, 0, 1'b1, 1'b0);
      run_dumps(2);

      while (power_pending) begin
         drive_sample();
      end
      repeat (3) drive_sample();
      if (channel_top_inst.channel_assert_inst.failures != 0) begin
         stop_with_failure("ERROR: a bound assertion on channel_top failed");
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- source/carrier_nco.sv
`default_nettype none

module carrier_nco (
   input  logic                              clk,
   input  logic                              i_rst_n,
   input  logic                              i_start,
   input  logic                              i_sample_valid,
   input  logic [channel_pkg::PHASE_W-1:0]   i_dphi,
   output channel_pkg::carrier_t             o_carrier
);

   localparam int PHASE_W  = channel_pkg::PHASE_W;
   localparam int OCTANT_W = 3;

   logic [PHASE_W-1:0]  phase_q;
   logic [OCTANT_W-1:0] octant;

   // Phase accumulator.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase_q <= '0;
      end else if (i_start) begin
         phase_q <= '0;
      end else if (i_sample_valid) begin
         phase_q <= phase_q + i_dphi;
      end
   end

   assign octant = phase_q[PHASE_W-1 -: OCTANT_W];

   // Table lookup of the current octant.
   always_comb begin
      o_carrier.cos = channel_pkg::CARRIER_COS[octant];
      o_carrier.sin = channel_pkg::CARRIER_SIN[octant];
   end

endmodule

`default_nettype wire

//--- source/channel_pkg.sv
`default_nettype none

package channel_pkg;

   // Datapath widths.
   localparam int SAMPLE_W  = 3;
   localparam int ACC_W     = 20;
   localparam int MAG_W     = 19;
   localparam int POWER_W   = 40;
   localparam int PHASE_W   = 16;
   localparam int COUNT_W   = 12;
   localparam int TAU_OFS_W = 8;
   localparam int IQ_W      = 32;

   typedef enum logic {
      MODE_IDLE,
      MODE_TRACK
   } mode_t;

   typedef enum logic [2:0] {
      PW_IDLE,
      PW_EARLY,
      PW_PROMPT,
      PW_LATE,
      PW_SUM
   } power_state_t;

   typedef struct packed {
      logic signed [2:0] cos;
      logic signed [2:0] sin;
   } carrier_t;

   // Carrier levels per phase octant.
   localparam logic signed [2:0] CARRIER_COS [0:7] = '{
      3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2
   };
   localparam logic signed [2:0] CARRIER_SIN [0:7] = '{
      3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1
   };

   typedef struct packed {
      logic signed [ACC_W-1:0] i;
      logic signed [ACC_W-1:0] q;
   } corr_t;

   typedef struct packed {
      logic [POWER_W-1:0] early;
      logic [POWER_W-1:0] prompt;
      logic [POWER_W-1:0] late;
   } power_t;

   typedef struct packed {
      logic [IQ_W-1:0]             iq_prompt;
      logic [PHASE_W-1:0]          doppler_inc;
      logic signed [TAU_OFS_W-1:0] tau_offset;
   } loop_update_t;

   typedef struct packed {
      logic signed [ACC_W-1:0] i_prompt_k;
      logic signed [ACC_W-1:0] q_prompt_k;
      logic signed [ACC_W-1:0] i_prompt_km1;
      logic signed [ACC_W-1:0] q_prompt_km1;
      logic [IQ_W-1:0]         iq_prompt_km1;
      logic [PHASE_W-1:0]      carrier_dphi;
      logic [COUNT_W-1:0]      tau_prime;
   } loop_state_t;

endpackage

`default_nettype wire

//--- source/channel_top.sv
`default_nettype none

module channel_top #(
   parameter int NOMINAL_COUNT = 64,
   parameter int SQUARE_LAT    = 2
) (
   input  logic                                    clk,
   input  logic                                    i_rst_n,
   input  channel_pkg::mode_t                      i_mode,
   input  logic                                    i_sample_valid,
   input  logic signed [channel_pkg::SAMPLE_W-1:0] i_sample,
   input  logic                                    i_code_chip,
   input  logic                                    i_tracking_ready,
   input  channel_pkg::loop_update_t               i_loop_update,
   input  logic                                    i_track_carrier_en,
   input  logic                                    i_track_code_en,
   output logic                                    o_dump,
   output channel_pkg::corr_t                      o_prompt,
   output logic                                    o_power_valid,
   output channel_pkg::power_t                     o_power,
   output channel_pkg::loop_state_t                o_loop_state
);

   logic                  start;
   logic                  last;
   channel_pkg::carrier_t carrier;
   channel_pkg::corr_t    early;
   channel_pkg::corr_t    late;

   loop_control #(
      .NOMINAL_COUNT(NOMINAL_COUNT)
   ) loop_control_inst (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_mode             (i_mode),
      .i_sample_valid     (i_sample_valid),
      .i_tracking_ready   (i_tracking_ready),
      .i_loop_update      (i_loop_update),
      .i_track_carrier_en (i_track_carrier_en),
      .i_track_code_en    (i_track_code_en),
      .i_prompt           (o_prompt),
      .o_start            (start),
      .o_last             (last),
      .o_dump             (o_dump),
      .o_loop_state       (o_loop_state)
   );

   carrier_nco carrier_nco_inst (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_start        (start),
      .i_sample_valid (i_sample_valid),
      .i_dphi         (o_loop_state.carrier_dphi),
      .o_carrier      (carrier)
   );

   // Early, prompt and late taps.
   correlator #(.TAP_DELAY(0)) early_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(start), .i_sample_valid(i_sample_valid),
      .i_last(last), .i_sample(i_sample), .i_code_chip(i_code_chip),
      .i_carrier(carrier), .o_result(early)
   );

   correlator #(.TAP_DELAY(1)) prompt_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(start), .i_sample_valid(i_sample_valid),
      .i_last(last), .i_sample(i_sample), .i_code_chip(i_code_chip),
      .i_carrier(carrier), .o_result(o_prompt)
   );

   correlator #(.TAP_DELAY(2)) late_inst (
      .clk(clk), .i_rst_n(i_rst_n), .i_start(start), .i_sample_valid(i_sample_valid),
      .i_last(last), .i_sample(i_sample), .i_code_chip(i_code_chip),
      .i_carrier(carrier), .o_result(late)
   );

   power_pipeline #(
      .SQUARE_LAT(SQUARE_LAT)
   ) power_pipeline_inst (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_dump        (o_dump),
      .i_early       (early),
      .i_prompt      (o_prompt),
      .i_late        (late),
      .o_power       (o_power),
      .o_power_valid (o_power_valid)
   );

endmodule

`default_nettype wire

//--- source/correlator.sv
`default_nettype none

module correlator #(
   parameter int TAP_DELAY = 0
) (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_start,
   input  logic                                  i_sample_valid,
   input  logic                                  i_last,
   input  logic signed [channel_pkg::SAMPLE_W-1:0] i_sample,
   input  logic                                  i_code_chip,
   input  channel_pkg::carrier_t                 i_carrier,
   output channel_pkg::corr_t                    o_result
);

   localparam int ACC_W  = channel_pkg::ACC_W;
   localparam int PROD_W = channel_pkg::SAMPLE_W + 3;

   logic                     chip;
   logic signed [PROD_W-1:0] prod_i;
   logic signed [PROD_W-1:0] prod_q;
   logic signed [PROD_W-1:0] term_i;
   logic signed [PROD_W-1:0] term_q;
   logic signed [ACC_W-1:0]  sum_i;
   logic signed [ACC_W-1:0]  sum_q;
   logic signed [ACC_W-1:0]  next_i;
   logic signed [ACC_W-1:0]  next_q;

   // Code tap, delayed by valid samples only.
   generate
      if (TAP_DELAY == 0) begin : g_no_delay
         assign chip = i_code_chip;
      end else begin : g_delay
         logic [TAP_DELAY-1:0] taps_q;

         always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
               taps_q <= '0;
            end else if (i_sample_valid) begin
               taps_q[0] <= i_code_chip;
               for (int k = 1; k < TAP_DELAY; k++) begin
                  taps_q[k] <= taps_q[k-1];
               end
            end
         end

         assign chip = taps_q[TAP_DELAY-1];
      end
   endgenerate

   // Carrier and code wipe-off.
   assign prod_i = i_sample * $signed(i_carrier.cos);
   assign prod_q = i_sample * $signed(i_carrier.sin);
   assign term_i = chip ? prod_i : -prod_i;
   assign term_q = chip ? prod_q : -prod_q;
   assign next_i = sum_i + term_i;
   assign next_q = sum_q + term_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sum_i    <= '0;
         sum_q    <= '0;
         o_result <= '0;
      end else if (i_start) begin
         sum_i <= '0;
         sum_q <= '0;
      end else if (i_sample_valid) begin
         if (i_last) begin
            // Dump including the last product.
            o_result.i <= next_i;
            o_result.q <= next_q;
            sum_i      <= '0;
            sum_q      <= '0;
         end else begin
            sum_i <= next_i;
            sum_q <= next_q;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/loop_control.sv
`default_nettype none

module loop_control #(
   parameter int NOMINAL_COUNT = 64
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  channel_pkg::mode_t        i_mode,
   input  logic                      i_sample_valid,
   input  logic                      i_tracking_ready,
   input  channel_pkg::loop_update_t i_loop_update,
   input  logic                      i_track_carrier_en,
   input  logic                      i_track_code_en,
   input  channel_pkg::corr_t        i_prompt,
   output logic                      o_start,
   output logic                      o_last,
   output logic                      o_dump,
   output channel_pkg::loop_state_t  o_loop_state
);

   localparam int COUNT_W   = channel_pkg::COUNT_W;
   localparam int TAU_OFS_W = channel_pkg::TAU_OFS_W;
   localparam logic [COUNT_W-1:0] NOMINAL = COUNT_W'(NOMINAL_COUNT);

   channel_pkg::mode_t mode_q;
   logic               track;
   logic [COUNT_W-1:0] count_q;
   logic [COUNT_W-1:0] tau_active_q;
   logic [COUNT_W-1:0] tau_next;
   logic [COUNT_W-1:0] tau_ofs_ext;
   logic               ignore_doppler_q;

   assign track   = (i_mode == channel_pkg::MODE_TRACK);
   assign o_start = track && (mode_q != channel_pkg::MODE_TRACK);
   // Counter match against the length of the running integration.
   assign o_last  = track && (count_q == tau_active_q - COUNT_W'(1));

   assign tau_ofs_ext = {{(COUNT_W - TAU_OFS_W){i_loop_update.tau_offset[TAU_OFS_W-1]}},
                         i_loop_update.tau_offset};

   always_comb begin
      tau_next = o_loop_state.tau_prime;
      if (i_tracking_ready && i_track_code_en) begin
         tau_next = NOMINAL + tau_ofs_ext;
      end
   end

   // Sample counter and dump strobe.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mode_q       <= channel_pkg::MODE_IDLE;
         count_q      <= '0;
         tau_active_q <= '0;
         o_dump       <= 1'b0;
      end else begin
         mode_q <= i_mode;
         o_dump <= 1'b0;
         if (o_start) begin
            count_q      <= '0;
            tau_active_q <= NOMINAL;
         end else if (track && i_sample_valid) begin
            if (o_last) begin
               count_q      <= '0;
               tau_active_q <= tau_next;
               o_dump       <= 1'b1;
            end else begin
               count_q <= count_q + COUNT_W'(1);
            end
         end
      end
   end

   // History and controls for the tracking loop.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_loop_state     <= '0;
         ignore_doppler_q <= 1'b0;
      end else if (o_start) begin
         o_loop_state               <= '0;
         o_loop_state.iq_prompt_km1 <= channel_pkg::IQ_W'(1);
         o_loop_state.tau_prime     <= NOMINAL;
         ignore_doppler_q           <= 1'b1;
      end else begin
         o_loop_state.tau_prime <= tau_next;
         if (o_dump) begin
            o_loop_state.i_prompt_k <= i_prompt.i;
            o_loop_state.q_prompt_k <= i_prompt.q;
         end
         if (i_tracking_ready) begin
            o_loop_state.i_prompt_km1  <= o_loop_state.i_prompt_k;
            o_loop_state.q_prompt_km1  <= o_loop_state.q_prompt_k;
            o_loop_state.iq_prompt_km1 <= i_loop_update.iq_prompt;
            ignore_doppler_q           <= 1'b0;
            // First Doppler estimate after start is not trusted.
            if (i_track_carrier_en && !ignore_doppler_q) begin
               o_loop_state.carrier_dphi <= i_loop_update.doppler_inc;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/power_pipeline.sv
`default_nettype none

module power_pipeline #(
   parameter int SQUARE_LAT = 2
) (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_dump,
   input  channel_pkg::corr_t  i_early,
   input  channel_pkg::corr_t  i_prompt,
   input  channel_pkg::corr_t  i_late,
   output channel_pkg::power_t o_power,
   output logic                o_power_valid
);

   localparam int ACC_W   = channel_pkg::ACC_W;
   localparam int MAG_W   = channel_pkg::MAG_W;
   localparam int POWER_W = channel_pkg::POWER_W;
   localparam int SQ_W    = 2 * MAG_W;
   localparam int STEP_W  = $clog2(SQUARE_LAT + 1);
   localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(SQUARE_LAT);

   function automatic logic [MAG_W-1:0] magnitude(input logic signed [ACC_W-1:0] value);
      logic signed [ACC_W-1:0] abs_value;
      abs_value = value[ACC_W-1] ? -value : value;
      return abs_value[MAG_W-1:0];
   endfunction

   logic [MAG_W-1:0]          mag_i_q [3];
   logic [MAG_W-1:0]          mag_q_q [3];
   logic [MAG_W-1:0]          sel_i;
   logic [MAG_W-1:0]          sel_q;
   logic [SQ_W-1:0]           i2_pipe [SQUARE_LAT];
   logic [SQ_W-1:0]           q2_pipe [SQUARE_LAT];
   logic [POWER_W-1:0]        pair_sum;
   logic                      last_step;
   channel_pkg::power_state_t state_q;
   logic [STEP_W-1:0]         step_q;
   channel_pkg::power_t       partial_q;

   // Magnitudes of early, prompt and late, in that order.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int k = 0; k < 3; k++) begin
            mag_i_q[k] <= '0;
            mag_q_q[k] <= '0;
         end
      end else if (i_dump) begin
         mag_i_q[0] <= magnitude(i_early.i);
         mag_q_q[0] <= magnitude(i_early.q);
         mag_i_q[1] <= magnitude(i_prompt.i);
         mag_q_q[1] <= magnitude(i_prompt.q);
         mag_i_q[2] <= magnitude(i_late.i);
         mag_q_q[2] <= magnitude(i_late.q);
      end
   end

   always_comb begin
      case (state_q)
         channel_pkg::PW_EARLY: begin
            sel_i = mag_i_q[0];
            sel_q = mag_q_q[0];
         end
         channel_pkg::PW_PROMPT: begin
            sel_i = mag_i_q[1];
            sel_q = mag_q_q[1];
         end
         default: begin
            sel_i = mag_i_q[2];
            sel_q = mag_q_q[2];
         end
      endcase
   end

   // Shared squarers, SQUARE_LAT stages deep.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int k = 0; k < SQUARE_LAT; k++) begin
            i2_pipe[k] <= '0;
            q2_pipe[k] <= '0;
         end
      end else begin
         i2_pipe[0] <= sel_i * sel_i;
         q2_pipe[0] <= sel_q * sel_q;
         for (int k = 1; k < SQUARE_LAT; k++) begin
            i2_pipe[k] <= i2_pipe[k-1];
            q2_pipe[k] <= q2_pipe[k-1];
         end
      end
   end

   assign pair_sum  = i2_pipe[SQUARE_LAT-1] + q2_pipe[SQUARE_LAT-1];
   assign last_step = (step_q == LAST_STEP);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         partial_q <= '0;
      end else if (!i_dump && last_step) begin
         case (state_q)
            channel_pkg::PW_EARLY:  partial_q.early  <= pair_sum;
            channel_pkg::PW_PROMPT: partial_q.prompt <= pair_sum;
            channel_pkg::PW_LATE:   partial_q.late   <= pair_sum;
            default: ;
         endcase
      end
   end

   // Sequencer; a dump always restarts at early.
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q       <= channel_pkg::PW_IDLE;
         step_q        <= '0;
         o_power       <= '0;
         o_power_valid <= 1'b0;
      end else begin
         o_power_valid <= 1'b0;
         if (i_dump) begin
            state_q <= channel_pkg::PW_EARLY;
            step_q  <= '0;
         end else begin
            case (state_q)
               channel_pkg::PW_EARLY, channel_pkg::PW_PROMPT, channel_pkg::PW_LATE: begin
                  step_q <= last_step ? '0 : step_q + STEP_W'(1);
                  if (last_step) begin
                     case (state_q)
                        channel_pkg::PW_EARLY:  state_q <= channel_pkg::PW_PROMPT;
                        channel_pkg::PW_PROMPT: state_q <= channel_pkg::PW_LATE;
                        default:                state_q <= channel_pkg::PW_SUM;
                     endcase
                  end
               end
               channel_pkg::PW_SUM: begin
                  o_power       <= partial_q;
                  o_power_valid <= 1'b1;
                  state_q       <= channel_pkg::PW_IDLE;
               end
               default: state_q <= channel_pkg::PW_IDLE;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- sources.f
source/channel_pkg.sv
source/loop_control.sv
source/carrier_nco.sv
source/correlator.sv
source/power_pipeline.sv
source/channel_top.sv
sim/channel_assert.sv
sim/channel_tb.sv
